//--- dcache_subsystem.f
+incdir+include
source/dcache_pkg.sv
source/dcache.sv
source/store_queue.sv
source/mem_bus_arbiter.sv
source/dcache_subsystem.sv
bench/mem_model.sv
bench/tb_dcache_subsystem.sv

//--- Bender.yml
package:
  name: dcache_subsystem

export_include_dirs:
  - include

sources:
  - source/dcache_pkg.sv
  - source/dcache.sv
  - source/store_queue.sv
  - source/mem_bus_arbiter.sv
  - source/dcache_subsystem.sv
  - target: simulation
    files:
      - bench/mem_model.sv
      - bench/tb_dcache_subsystem.sv

//--- bench/tb_dcache_subsystem.sv
// tb_dcache_subsystem checks loads, write-through stores and bus ordering of the data cache
`timescale 1ns/1ps
`default_nettype none
`include "dcache_settings.svh"

module tb_dcache_subsystem;
    localparam int MISS        = 0;                     // load kinds
    localparam int HIT         = 1;
    localparam int ANY         = 2;
    localparam int NUM_STEPS   = 45;                    // load, store and drain calls in the sequence
    localparam int WATCHDOG_NS = 200 * NUM_STEPS * 20;  // 200 cycles per step

    logic                     clk;
    logic                     reset;
    logic                     ld_valid;
    logic [`XLEN-1:0]         ld_addr;
    logic                     st_valid;
    logic [`XLEN-1:0]         st_addr;
    logic [63:0]              st_data;
    logic                     ld_hit;
    logic [63:0]              ld_data;
    logic                     st_ready;
    dcache_pkg::bus_command_t mem_command;
    logic [`XLEN-1:0]         mem_addr;
    logic [63:0]              mem_data;
    logic [`MEM_TAG_BITS-1:0] mem_response;
    logic [`MEM_TAG_BITS-1:0] mem_tag;
    logic [63:0]              mem_rdata;
    logic                     heavy_refusal;

    logic [63:0]              shadow [0:255];  // expected memory and cache contents
    logic [95:0]              exp_stores [$];  // accepted stores not yet taken by memory
    logic                     take_valid;      // store accepted at the coming edge
    logic [95:0]              take_entry;
    logic                     bus_load_seen;
    logic [`XLEN-1:0]         bus_load_addr;
    logic                     ready_fell;
    string                    test_name;
    integer                   seed;

    dcache_subsystem i_dut (
        .clk (clk), .reset (reset), .ld_valid (ld_valid), .ld_addr (ld_addr),
        .st_valid (st_valid), .st_addr (st_addr), .st_data (st_data),
        .mem_response (mem_response), .mem_tag (mem_tag), .mem_rdata (mem_rdata),
        .ld_hit (ld_hit), .ld_data (ld_data), .st_ready (st_ready),
        .mem_command (mem_command), .mem_addr (mem_addr), .mem_data (mem_data)
    );

    mem_model i_mem (
        .clk (clk), .reset (reset), .heavy_refusal (heavy_refusal),
        .mem_command (mem_command), .mem_addr (mem_addr), .mem_data (mem_data),
        .mem_response (mem_response), .mem_tag (mem_tag), .mem_rdata (mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic expect_value(input string what, input logic [63:0] expected,
                                input logic [63:0] actual);
        assert (actual === expected)
            else abort_run($sformatf("mismatch in %s, %s: expected %h, actual %h",
                                     test_name, what, expected, actual));
    endtask

    // bus and store checks sampled mid cycle
    always @(negedge clk) begin
        logic [95:0] head;
        take_valid = !reset && st_valid && st_ready;
        take_entry = {st_addr, st_data};
        if (!reset) begin
            if (!st_ready) begin
                ready_fell = 1'b1;
                expect_value("stores undrained at st_ready low", `SQ_DEPTH, exp_stores.size());
            end
            if (mem_command == dcache_pkg::BUS_LOAD) begin
                assert (exp_stores.size() == 0)
                    else abort_run($sformatf("%s: BUS_LOAD at %h while %0d stores wait",
                                             test_name, mem_addr, exp_stores.size()));
                bus_load_seen = 1'b1;
                bus_load_addr = mem_addr;
            end
            if ((mem_command == dcache_pkg::BUS_STORE) && (mem_response != '0)) begin
                assert (exp_stores.size() != 0)
                    else abort_run($sformatf("%s: BUS_STORE at %h that was never accepted",
                                             test_name, mem_addr));
                head = exp_stores.pop_front();
                expect_value("store address on bus", head[95:64], mem_addr);
                expect_value("store data on bus", head[63:0], mem_data);
            end
        end
    end

    always @(posedge clk) begin
        if (take_valid) begin
            exp_stores.push_back(take_entry);
            shadow[take_entry[74:67]] = take_entry[63:0];   // address bits 10:3
        end
    end

    task automatic check_load(input logic [`XLEN-1:0] addr, input int kind);
        int waited;
        waited        = 0;
        bus_load_seen = 1'b0;
        ld_addr       = addr;
        ld_valid      = 1'b1;
        @(negedge clk);
        if (kind == MISS) begin
            assert (!ld_hit) else abort_run($sformatf("%s: load of %h hit, expected a miss",
                                                      test_name, addr));
        end
        if (kind == HIT) begin
            assert (ld_hit) else abort_run($sformatf("%s: load of %h missed, expected a hit",
                                                     test_name, addr));
            expect_value("bus command during hit", dcache_pkg::BUS_NONE, mem_command);
        end
        while (!ld_hit) begin
            waited++;
            assert (waited < 200) else abort_run($sformatf("%s: load of %h never hit",
                                                           test_name, addr));
            @(negedge clk);
        end
        if (kind == MISS) begin
            assert (bus_load_seen) else abort_run($sformatf("%s: no BUS_LOAD for %h",
                                                            test_name, addr));
            expect_value("fill address", {addr[`XLEN-1:3], 3'b000}, bus_load_addr);
        end
        expect_value("load data", shadow[addr[10:3]], ld_data);
        @(posedge clk);
        #2;
        ld_valid = 1'b0;
    endtask

    task automatic drive_store(input logic [`XLEN-1:0] addr, input logic [63:0] data);
        st_addr  = addr;
        st_data  = data;
        st_valid = 1'b1;
        @(negedge clk);
        while (!st_ready) begin   // held while the queue is full
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        st_valid = 1'b0;
    endtask

    task automatic wait_drain();
        do begin
            @(posedge clk);
            #2;
        end while (exp_stores.size() != 0);
    endtask

    initial begin
        dcache_pkg::dcache_state_t st;
        #(WATCHDOG_NS);
        st = i_dut.i_dcache.state;
        abort_run($sformatf("timeout during %s, cache state %s", test_name, st.name()));
    end

    initial begin
        logic [31:0]      r;
        logic [`XLEN-1:0] a;
        logic [63:0]      d;
        seed = 94;
        test_name = "reset";
        reset = 1'b1;
        ld_valid = 1'b0;
        ld_addr = '0;
        st_valid = 1'b0;
        st_addr = '0;
        st_data = '0;
        heavy_refusal = 1'b0;
        ready_fell = 1'b0;
        take_valid = 1'b0;
        bus_load_seen = 1'b0;
        bus_load_addr = '0;
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;
        for (int k = 0; k < 256; k++) begin
            shadow[k] = i_mem.words[k];   // start from the model's fill pattern
        end

        test_name = "cold miss";
        check_load(32'h040, MISS);
        check_load(32'h08c, MISS);   // offset inside the line
        check_load(32'h1fd, MISS);
        test_name = "hit without traffic";
        check_load(32'h040, HIT);
        check_load(32'h088, HIT);
        test_name = "conflict eviction";
        check_load(32'h140, MISS);   // same index as 0x040
        check_load(32'h040, MISS);
        check_load(32'h140, MISS);

        test_name = "write-through";
        drive_store(32'h140, 64'h0123_4567_89ab_cdef);   // write hit
        check_load(32'h140, ANY);
        drive_store(32'h300, 64'hfeed_face_cafe_0300);   // write miss leaves the cache alone
        check_load(32'h300, MISS);
        wait_drain();
        check_load(32'h140, HIT);

        test_name = "store during fill";
        fork
            check_load(32'h406, MISS);
            begin
                repeat (3) @(posedge clk);
                #2;
                drive_store(32'h400, 64'h5a5a_0400_a5a5_0400);
            end
        join
        wait_drain();

        test_name = "back-pressure";
        heavy_refusal = 1'b1;
        ready_fell = 1'b0;
        for (int k = 0; k < 10; k++) begin
            d = {$random(seed), $random(seed)};
            drive_store(32'h500 + 32'(k) * 8, d);
        end
        assert (ready_fell) else abort_run("back-pressure: st_ready never fell");
        heavy_refusal = 1'b0;
        wait_drain();

        test_name = "random mix";
        for (int k = 0; k < 16; k++) begin
            r = $random(seed);
            a = 32'(r[5:4]) * 32'h100 + 32'(r[2:1]) * 8;   // four tags on four lines
            if (r[0]) begin
                d = {$random(seed), $random(seed)};
                drive_store(a, d);
            end else begin
                check_load(a, ANY);
            end
        end
        wait_drain();

        test_name = "final memory";
        for (int k = 0; k < 256; k++) begin
            expect_value($sformatf("word %0d", k), shadow[k], i_mem.words[k]);
        end
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/mem_model.sv
// mem_model is a tagged doubleword memory with random refusals and variable load latency
`timescale 1ns/1ps
`default_nettype none
`include "dcache_settings.svh"

module mem_model (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     heavy_refusal,   // refuse about three requests in four
    input  dcache_pkg::bus_command_t mem_command,
    input  logic [`XLEN-1:0]         mem_addr,
    input  logic [63:0]              mem_data,
    output logic [`MEM_TAG_BITS-1:0] mem_response,    // zero means refused
    output logic [`MEM_TAG_BITS-1:0] mem_tag,
    output logic [63:0]              mem_rdata
);
    logic [63:0]              words [0:255];   // 2 KB, aliases above that
    integer                   seed;
    integer                   rnd;
    logic                     accept_ok;       // drawn once per cycle
    logic [`MEM_TAG_BITS-1:0] next_tag;        // never zero
    logic                     busy;            // one fill in flight at most
    logic [2:0]               wait_cnt;
    logic [`MEM_TAG_BITS-1:0] load_tag;
    logic [63:0]              load_data;       // line read when the fill was accepted
    logic                     take;
    logic [7:0]               word_idx;

    initial begin
        seed = 94;
        for (int k = 0; k < 256; k++) begin
            words[k] = {32'(k) * 32'h0101_0101 + 32'h1357_9bdf, ~(32'(k) << 3)};
        end
    end

    assign word_idx     = mem_addr[10:3];
    assign take         = accept_ok && ((mem_command == dcache_pkg::BUS_STORE)
                          || ((mem_command == dcache_pkg::BUS_LOAD) && !busy));
    assign mem_response = take ? next_tag : '0;
    assign mem_tag      = (busy && (wait_cnt == 3'd0)) ? load_tag : '0;   // one cycle pulse
    assign mem_rdata    = load_data;

    always @(posedge clk) begin
        rnd = $random(seed);
        if (reset) begin
            accept_ok <= 1'b0;
            next_tag  <= 1;
            busy      <= 1'b0;
            wait_cnt  <= '0;
            load_tag  <= '0;
        end else begin
            accept_ok <= heavy_refusal ? (rnd[1:0] == 2'd0) : (rnd[1:0] != 2'd0);
            if (take) begin
                next_tag <= (next_tag == '1) ? 1 : next_tag + 1'b1;   // skip zero
            end
            if (take && (mem_command == dcache_pkg::BUS_STORE)) begin
                words[word_idx] <= mem_data;
            end
            if (take && (mem_command == dcache_pkg::BUS_LOAD)) begin
                busy      <= 1'b1;
                load_tag  <= next_tag;
                load_data <= words[word_idx];
                wait_cnt  <= 3'(1 + (rnd[9:4] % 5));   // data 2 to 6 cycles after request
            end else if (busy) begin
                if (wait_cnt == 3'd0) begin
                    busy <= 1'b0;
                end else begin
                    wait_cnt <= wait_cnt - 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- source/dcache_subsystem.sv
// dcache_subsystem joins the data cache, store queue and memory bus arbiter
`timescale 1ns/1ps
`default_nettype none
`include "dcache_settings.svh"

module dcache_subsystem (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      ld_valid,
    input  logic [`XLEN-1:0]          ld_addr,
    input  logic                      st_valid,
    input  logic [`XLEN-1:0]          st_addr,
    input  logic [63:0]               st_data,
    input  logic [`MEM_TAG_BITS-1:0]  mem_response,
    input  logic [`MEM_TAG_BITS-1:0]  mem_tag,
    input  logic [63:0]               mem_rdata,
    output logic                      ld_hit,
    output logic [63:0]               ld_data,
    output logic                      st_ready,
    output dcache_pkg::bus_command_t  mem_command,
    output logic [`XLEN-1:0]          mem_addr,
    output logic [63:0]               mem_data
);
    logic                     fill_req;
    logic [`XLEN-1:0]         fill_addr;
    logic [`MEM_TAG_BITS-1:0] fill_grant_tag;
    logic                     sq_valid;
    logic [`XLEN-1:0]         sq_addr;
    logic [63:0]              sq_data;
    logic                     sq_pop;

    dcache i_dcache (
        .clk            (clk),
        .reset          (reset),
        .ld_valid       (ld_valid),
        .ld_addr        (ld_addr),
        .st_valid       (st_valid),
        .st_ready       (st_ready),        // cache sees the same store handshake as the queue
        .st_addr        (st_addr),
        .st_data        (st_data),
        .fill_grant_tag (fill_grant_tag),
        .mem_tag        (mem_tag),
        .mem_rdata      (mem_rdata),
        .ld_hit         (ld_hit),
        .ld_data        (ld_data),
        .fill_req       (fill_req),
        .fill_addr      (fill_addr)
    );

    store_queue #(
        .DEPTH (`SQ_DEPTH)
    ) i_store_queue (
        .clk      (clk),
        .reset    (reset),
        .st_valid (st_valid),
        .st_addr  (st_addr),
        .st_data  (st_data),
        .sq_pop   (sq_pop),
        .st_ready (st_ready),
        .sq_valid (sq_valid),
        .sq_addr  (sq_addr),
        .sq_data  (sq_data)
    );

    mem_bus_arbiter i_mem_bus_arbiter (
        .clk            (clk),
        .reset          (reset),
        .sq_valid       (sq_valid),
        .sq_addr        (sq_addr),
        .sq_data        (sq_data),
        .fill_req       (fill_req),
        .fill_addr      (fill_addr),
        .mem_response   (mem_response),
        .sq_pop         (sq_pop),
        .fill_grant_tag (fill_grant_tag),
        .mem_command    (mem_command),
        .mem_addr       (mem_addr),
        .mem_data       (mem_data)
    );

endmodule

`default_nettype wire

//--- source/mem_bus_arbiter.sv
// mem_bus_arbiter shares the memory port between store drains and line fills
`timescale 1ns/1ps
`default_nettype none
`include "dcache_settings.svh"

module mem_bus_arbiter (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      sq_valid,        // store queue head present
    input  logic [`XLEN-1:0]          sq_addr,
    input  logic [63:0]               sq_data,
    input  logic                      fill_req,        // cache wants a line
    input  logic [`XLEN-1:0]          fill_addr,
    input  logic [`MEM_TAG_BITS-1:0]  mem_response,    // zero when memory refuses
    output logic                      sq_pop,
    output logic [`MEM_TAG_BITS-1:0]  fill_grant_tag,
    output dcache_pkg::bus_command_t  mem_command,
    output logic [`XLEN-1:0]          mem_addr,
    output logic [63:0]               mem_data
);
    logic store_sel;         // store owns the bus this cycle
    logic fill_sel;          // fill owns the bus this cycle
    logic store_granted_q;   // previous cycle ended with a store accepted

    // Stores always win. A fill waits until the queue is empty and one more cycle after the
    // last store was accepted, so it can not pass the pop edge of that store.
    assign store_sel = sq_valid;
    assign fill_sel  = fill_req && !sq_valid && !store_granted_q;

    always_comb begin
        mem_command = dcache_pkg::BUS_NONE;
        mem_addr    = '0;
        mem_data    = '0;
        if (store_sel) begin
            mem_command = dcache_pkg::BUS_STORE;
            mem_addr    = sq_addr;
            mem_data    = sq_data;
        end else if (fill_sel) begin
            mem_command = dcache_pkg::BUS_LOAD;
            mem_addr    = fill_addr;   // already line aligned
        end
    end

    // response tag goes back only to the requester that drove the bus
    assign sq_pop         = store_sel && (mem_response != '0);
    assign fill_grant_tag = fill_sel ? mem_response : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            store_granted_q <= 1'b0;
        end else begin
            store_granted_q <= sq_pop;
        end
    end

endmodule

`default_nettype wire

//--- source/store_queue.sv
// store_queue is a FIFO of write-through stores waiting for the memory bus
`timescale 1ns/1ps
`default_nettype none
`include "dcache_settings.svh"

module store_queue #(
    parameter int DEPTH = `SQ_DEPTH
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             st_valid,
    input  logic [`XLEN-1:0] st_addr,
    input  logic [63:0]      st_data,
    input  logic             sq_pop,     // head taken by memory this cycle
    output logic             st_ready,   // low only when full and nothing leaves
    output logic             sq_valid,   // head entry present
    output logic [`XLEN-1:0] sq_addr,
    output logic [63:0]      sq_data
);
    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    logic [`XLEN-1:0]    q_addr [0:DEPTH-1];
    logic [63:0]         q_data [0:DEPTH-1];
    logic [PTR_BITS-1:0] wr_ptr;   // next free slot
    logic [PTR_BITS-1:0] rd_ptr;   // oldest entry
    logic [CNT_BITS-1:0] count;
    logic                full;
    logic                push;
    logic                pop;

    // wrap for any depth, power of two or not
    function automatic logic [PTR_BITS-1:0] ptr_inc(input logic [PTR_BITS-1:0] ptr);
        if (ptr == PTR_BITS'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full     = (count == CNT_BITS'(DEPTH));
    assign sq_valid = (count != '0);
    assign st_ready = !full || sq_pop;     // full queue still takes a store while the head leaves
    assign push     = st_valid && st_ready;
    assign pop      = sq_pop && sq_valid;

    assign sq_addr = q_addr[rd_ptr];
    assign sq_data = q_data[rd_ptr];

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // entry storage
    always_ff @(posedge clk) begin
        if (push) begin
            q_addr[wr_ptr] <= st_addr;
            q_data[wr_ptr] <= st_data;   // when full this slot is the head leaving now
        end
    end

endmodule

`default_nettype wire

//--- source/dcache.sv
// dcache is a direct-mapped write-through data cache with a single outstanding line fill
`timescale 1ns/1ps
`default_nettype none
`include "dcache_settings.svh"

module dcache (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     ld_valid,        // held by the processor until ld_hit
    input  logic [`XLEN-1:0]         ld_addr,
    input  logic                     st_valid,
    input  logic                     st_ready,        // store queue has room
    input  logic [`XLEN-1:0]         st_addr,
    input  logic [63:0]              st_data,
    input  logic [`MEM_TAG_BITS-1:0] fill_grant_tag,  // nonzero when memory takes the fill
    input  logic [`MEM_TAG_BITS-1:0] mem_tag,         // data tag from memory
    input  logic [63:0]              mem_rdata,
    output logic                     ld_hit,
    output logic [63:0]              ld_data,         // only meaningful with ld_hit
    output logic                     fill_req,
    output logic [`XLEN-1:0]         fill_addr        // line aligned
);
    localparam int LINES    = 1 << `DCACHE_INDEX_BITS;
    localparam int LINE_LSB = `DCACHE_OFFSET_BITS;                     // lowest line address bit
    localparam int TAG_LSB  = `DCACHE_INDEX_BITS + `DCACHE_OFFSET_BITS;

    logic [63:0]                   cache_data [0:LINES-1];  // one doubleword per line
    logic [`DCACHE_TAG_BITS-1:0]   cache_tag  [0:LINES-1];
    logic [LINES-1:0]              cache_valid;

    logic [`DCACHE_TAG_BITS-1:0]   ld_tag;
    logic [`DCACHE_INDEX_BITS-1:0] ld_index;
    logic [`DCACHE_TAG_BITS-1:0]   st_tag;
    logic [`DCACHE_INDEX_BITS-1:0] st_index;
    logic [`DCACHE_INDEX_BITS-1:0] miss_index;

    dcache_pkg::dcache_state_t     state;
    dcache_pkg::dcache_state_t     state_next;
    logic [`XLEN-1:0]              miss_addr;         // address of the load that missed
    logic [`MEM_TAG_BITS-1:0]      miss_tag;          // bus tag of the fill in flight
    logic                          stale;             // newer store overtook the fill

    logic                          miss_start;
    logic                          st_accept;
    logic                          st_hit;
    logic                          st_on_miss_line;
    logic                          stale_set;
    logic                          fill_done;
    logic                          fill_write;

    // address split
    assign ld_tag     = ld_addr[`XLEN-1:TAG_LSB];
    assign ld_index   = ld_addr[TAG_LSB-1:LINE_LSB];
    assign st_tag     = st_addr[`XLEN-1:TAG_LSB];
    assign st_index   = st_addr[TAG_LSB-1:LINE_LSB];
    assign miss_index = miss_addr[TAG_LSB-1:LINE_LSB];

    // load lookup, zero latency
    assign ld_hit  = cache_valid[ld_index] && (cache_tag[ld_index] == ld_tag);
    assign ld_data = cache_data[ld_index];

    assign miss_start = (state == dcache_pkg::IDLE) && ld_valid && !ld_hit;

    // store side, seen directly on the processor handshake
    assign st_accept       = st_valid && st_ready;
    assign st_hit          = cache_valid[st_index] && (cache_tag[st_index] == st_tag);
    assign st_on_miss_line = st_accept
                             && (st_addr[`XLEN-1:LINE_LSB] == miss_addr[`XLEN-1:LINE_LSB]);

    // A store to the miss line accepted once the fill is on the bus reaches memory after
    // the fill read, so the returning line would be old. Before the grant the queue drains
    // first and the fill sees the new data.
    assign stale_set = st_on_miss_line
                       && (((state == dcache_pkg::MISS_REQ) && (fill_grant_tag != '0))
                           || (state == dcache_pkg::MISS_WAIT));

    assign fill_req  = (state == dcache_pkg::MISS_REQ);
    assign fill_addr = {miss_addr[`XLEN-1:LINE_LSB], {LINE_LSB{1'b0}}};

    assign fill_done  = (state == dcache_pkg::MISS_WAIT) && (mem_tag != '0)
                        && (mem_tag == miss_tag);
    assign fill_write = fill_done && !stale && !st_on_miss_line;  // same-edge store drops it too

    always_comb begin
        state_next = state;
        case (state)
            dcache_pkg::IDLE: begin
                if (miss_start) state_next = dcache_pkg::MISS_REQ;
            end
            dcache_pkg::MISS_REQ: begin
                if (fill_grant_tag != '0) state_next = dcache_pkg::MISS_WAIT;  // memory took it
            end
            dcache_pkg::MISS_WAIT: begin
                if (fill_done) state_next = dcache_pkg::IDLE;  // back even if the line was dropped
            end
            default: state_next = dcache_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= dcache_pkg::IDLE;
            cache_valid <= '0;             // every load misses after reset
            miss_tag    <= '0;
            stale       <= 1'b0;
        end else begin
            state <= state_next;
            if (miss_start) begin
                stale <= 1'b0;             // new miss starts clean
            end else if (stale_set) begin
                stale <= 1'b1;
            end
            if (fill_req && (fill_grant_tag != '0)) begin
                miss_tag <= fill_grant_tag;
            end
            if (fill_write) begin
                cache_valid[miss_index] <= 1'b1;
            end
        end
    end

    // arrays and miss address
    always_ff @(posedge clk) begin
        if (miss_start) begin
            miss_addr <= ld_addr;
        end
        if (st_accept && st_hit) begin
            cache_data[st_index] <= st_data;   // write hit, a write miss allocates nothing
        end
        if (fill_write) begin
            cache_data[miss_index] <= mem_rdata;   // a fill replacing the indexed line wins
            cache_tag[miss_index]  <= miss_addr[`XLEN-1:TAG_LSB];
        end
    end

endmodule

`default_nettype wire

//--- source/dcache_pkg.sv
// dcache package holding the memory bus command and cache miss state types
`default_nettype none

package dcache_pkg;

    // command driven onto the tagged memory bus
    typedef enum logic [1:0] {
        BUS_NONE  = 2'h0,   // bus idle
        BUS_LOAD  = 2'h1,   // read one line
        BUS_STORE = 2'h2    // write one doubleword
    } bus_command_t;

    // miss handling state of the data cache
    // only one miss is outstanding at any time
    typedef enum logic [1:0] {
        IDLE      = 2'h0,   // lookups only
        MISS_REQ  = 2'h1,   // fill request waits for the bus
        MISS_WAIT = 2'h2    // fill accepted, waiting for its data tag
    } dcache_state_t;

endpackage

`default_nettype wire

//--- include/dcache_settings.svh
// dcache settings with the address split, memory bus tag width and store queue depth
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// processor address width in bits
`define XLEN 32

// byte offset inside one 8-byte line
`define DCACHE_OFFSET_BITS 3

// line index bits, 32 lines of one doubleword each
`define DCACHE_INDEX_BITS 5

// whatever is left of the address above index and offset
`define DCACHE_TAG_BITS (`XLEN - `DCACHE_INDEX_BITS - `DCACHE_OFFSET_BITS)

// memory transaction tag width
// a value of zero on the bus means no transaction
`define MEM_TAG_BITS 4

// default number of write-through stores waiting for the bus
`define SQ_DEPTH 4

`endif
